/* Bender.yml */
package:
  name: sram_tc

sources:
  - include_dirs:
      - source
    files:
      - source/sram_tc_pkg.sv
      - source/sram_tc_ctrl.sv
      - source/sram_tc_bank.sv
      - source/sram_tc_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/sram_tc_sva.sv
      - verification/sram_tc_tb.sv

/* files.f */
+incdir+source
source/sram_tc_pkg.sv
source/sram_tc_ctrl.sv
source/sram_tc_bank.sv
source/sram_tc_top.sv
verification/sram_tc_sva.sv
verification/sram_tc_tb.sv

/* source/sram_tc_bank.sv */
/*
 * dual-port sram bank model
 * port 0 read-write with byte mask, port 1 read-only,
 * capture registers on both outputs
 */
`timescale 1ns/1ns
`default_nettype none

module sram_tc_bank #(
   parameter type DATA_T = sram_tc_pkg::word_t,
   parameter int  DEPTH  = 1024
) (
   input  logic                clk,
   input  logic                rstn,
   // read-write port
   input  logic                csb0_i,
   input  logic                web0_i,
   input  sram_tc_pkg::strb_t  wmask0_i,
   input  sram_tc_pkg::waddr_t addr0_i,
   input  sram_tc_pkg::word_t  din0_i,
   // read-only port
   input  logic                csb1_i,
   input  sram_tc_pkg::waddr_t addr1_i,
   // captured outputs
   output sram_tc_pkg::word_t  data0_o,
   output sram_tc_pkg::word_t  data1_o
);
   import sram_tc_pkg::*;

   localparam int DATA_W = $bits(DATA_T);
   // byte lanes actually stored
   localparam int NB     = DATA_W / 8;
   localparam int AW     = $clog2(DEPTH);

   DATA_T mem [DEPTH];
   DATA_T din_w;
   DATA_T dout0_q;
   DATA_T dout1_q;

   // narrow banks keep the low lanes of the bus
   assign din_w = DATA_T'(din0_i);

   // port 0, write or read on the edge
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            for (int i = 0; i < NB; i++) begin
               // masked lanes keep their old value
               if (wmask0_i[i]) begin
                  mem[addr0_i[AW-1:0]][8*i +: 8] <= din_w[8*i +: 8];
               end
            end
         end else begin
            dout0_q <= mem[addr0_i[AW-1:0]];
         end
      end
   end

   // port 1, read only
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_q <= mem[addr1_i[AW-1:0]];
      end
   end

   // macro outputs hold while deselected
   // capture runs every cycle, one behind the array read
   always_ff @(posedge clk) begin
      if (!rstn) begin
         data0_o <= '0;
         data1_o <= '0;
      end else begin
         // zero-extend to the bus width
         data0_o <= word_t'(dout0_q);
         data1_o <= word_t'(dout1_q);
      end
   end

endmodule

`default_nettype wire

/* source/sram_tc_config.svh */
/*
 * sram test-chip configuration
 * bank count, bank depths and the apb address field layout
 */
`ifndef SRAM_TC_CONFIG_SVH
`define SRAM_TC_CONFIG_SVH

// bank population
`define SRAM_TC_NUM_BANKS 4
`define SRAM_TC_DEPTH0    1024
`define SRAM_TC_DEPTH1    256
`define SRAM_TC_DEPTH2    512
`define SRAM_TC_DEPTH3    1024

// apb address layout, byte addressed
`define SRAM_TC_ADDR_W    17
`define SRAM_TC_BANK_LSB  12
`define SRAM_TC_BANK_W    4
`define SRAM_TC_PORT_BIT  16
`define SRAM_TC_WADDR_LSB 2
`define SRAM_TC_WADDR_W   10

// data path
`define SRAM_TC_DATA_W    32
`define SRAM_TC_STRB_W    4
`endif

/* source/sram_tc_ctrl.sv */
/*
 * sram test-chip controller
 * apb slave fsm, address decode, chip-select drive and read-data select
 */
`timescale 1ns/1ns
`default_nettype none

`include "sram_tc_config.svh"

module sram_tc_ctrl (
   input  logic                           clk,
   input  logic                           rstn,
   input  logic [`SRAM_TC_ADDR_W-1:0]     paddr_i,
   input  logic                           psel_i,
   input  logic                           penable_i,
   input  logic                           pwrite_i,
   input  sram_tc_pkg::word_t             pwdata_i,
   input  sram_tc_pkg::strb_t             pstrb_i,
   input  sram_tc_pkg::bank_word_t        cap0_i,
   input  sram_tc_pkg::bank_word_t        cap1_i,
   output sram_tc_pkg::word_t             prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o,
   output sram_tc_pkg::waddr_t            addr0_o,
   output sram_tc_pkg::waddr_t            addr1_o,
   output sram_tc_pkg::word_t             din0_o,
   output logic                           web0_o,
   output sram_tc_pkg::strb_t             wmask0_o,
   output sram_tc_pkg::bank_mask_t        csb0_o,
   output sram_tc_pkg::bank_mask_t        csb1_o
);
   import sram_tc_pkg::*;

   localparam int BQ_W = $clog2(`SRAM_TC_NUM_BANKS);

   logic [`SRAM_TC_BANK_W-1:0] bank_sel;
   logic                       port_sel;
   waddr_t                     waddr;
   logic                       depth_ok;
   logic                       err;
   logic                       start;
   bank_mask_t                 bank_mask;
   ctrl_state_t                state_q;
   logic [BQ_W-1:0]            bank_q;
   logic                       port_q;
   logic                       write_q;
   logic                       err_q;

   // address fields
   assign bank_sel  = paddr_i[`SRAM_TC_BANK_LSB +: `SRAM_TC_BANK_W];
   assign port_sel  = paddr_i[`SRAM_TC_PORT_BIT];
   assign waddr     = paddr_i[`SRAM_TC_WADDR_LSB +: `SRAM_TC_WADDR_W];
   assign bank_mask = ~(bank_mask_t'(1) << bank_sel);

   // word address against the depth of the addressed bank
   always_comb begin
      case (bank_sel)
         4'd0:    depth_ok = (waddr < `SRAM_TC_DEPTH0);
         4'd1:    depth_ok = (waddr < `SRAM_TC_DEPTH1);
         4'd2:    depth_ok = (waddr < `SRAM_TC_DEPTH2);
         4'd3:    depth_ok = (waddr < `SRAM_TC_DEPTH3);
         default: depth_ok = 1'b0;
      endcase
   end

   // port 1 is read-only
   assign err   = (bank_sel >= `SRAM_TC_NUM_BANKS) || !depth_ok || (pwrite_i && port_sel);
   // setup phase starts a transfer
   assign start = (state_q == IDLE) && psel_i && !penable_i;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= IDLE;
         csb0_o  <= '1;
         csb1_o  <= '1;
         web0_o  <= 1'b1;
         write_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         // selects and write enable only ever pulse for one cycle
         csb0_o <= '1;
         csb1_o <= '1;
         web0_o <= 1'b1;
         case (state_q)
            IDLE: begin
               if (start) begin
                  state_q <= ISSUE;
                  write_q <= pwrite_i;
                  err_q   <= err;
                  // a bad address selects no bank
                  if (!err && !port_sel) begin
                     csb0_o <= bank_mask;
                  end
                  if (!err && port_sel) begin
                     csb1_o <= bank_mask;
                  end
                  web0_o <= !(pwrite_i && !err);
               end
            end
            // writes and errors finish right away
            ISSUE:   state_q <= (err_q || write_q) ? DONE : READ;
            READ:    state_q <= CAPT;
            CAPT:    state_q <= DONE;
            DONE:    state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // request payload and read data
   always_ff @(posedge clk) begin
      if (start) begin
         addr0_o  <= waddr;
         addr1_o  <= waddr;
         din0_o   <= pwdata_i;
         wmask0_o <= pstrb_i;
         bank_q   <= bank_sel[BQ_W-1:0];
         port_q   <= port_sel;
      end
      // zero unless a good read overwrites it
      if (state_q == ISSUE) begin
         prdata_o <= '0;
      end
      if (state_q == CAPT) begin
         prdata_o <= port_q ? cap1_i[bank_q] : cap0_i[bank_q];
      end
   end

   // one-cycle completion
   assign pready_o  = (state_q == DONE);
   assign pslverr_o = (state_q == DONE) && err_q;

endmodule

`default_nettype wire

/* source/sram_tc_pkg.sv */
/*
 * sram test-chip package
 * shared data, address and state types
 */
`default_nettype none

`include "sram_tc_config.svh"

package sram_tc_pkg;

   // bus word and its byte lanes
   typedef logic [`SRAM_TC_DATA_W-1:0] word_t;
   typedef logic [7:0]                 byte_t;
   typedef logic [`SRAM_TC_STRB_W-1:0] strb_t;

   // word address into any bank
   typedef logic [`SRAM_TC_WADDR_W-1:0] waddr_t;

   // one active-low select per bank
   typedef logic [`SRAM_TC_NUM_BANKS-1:0] bank_mask_t;

   // captured words, one per bank
   typedef word_t [`SRAM_TC_NUM_BANKS-1:0] bank_word_t;

   // transfer sequencing
   typedef enum logic [2:0] {
      IDLE,
      ISSUE,
      READ,
      CAPT,
      DONE
   } ctrl_state_t;

endpackage

`default_nettype wire

/* source/sram_tc_top.sv */
/*
 * sram test-chip top
 * apb controller driving four dual-port banks on shared buses
 */
`timescale 1ns/1ns
`default_nettype none

`include "sram_tc_config.svh"

module sram_tc_top (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic [`SRAM_TC_ADDR_W-1:0] paddr_i,
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  sram_tc_pkg::word_t         pwdata_i,
   input  sram_tc_pkg::strb_t         pstrb_i,
   output sram_tc_pkg::word_t         prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o
);
   import sram_tc_pkg::*;

   // shared bank buses
   waddr_t     addr0;
   waddr_t     addr1;
   word_t      din0;
   logic       web0;
   strb_t      wmask0;
   // per-bank selects
   bank_mask_t csb0;
   bank_mask_t csb1;
   // captured read data
   bank_word_t cap0;
   bank_word_t cap1;

   sram_tc_ctrl u_ctrl (
      .clk       (clk),
      .rstn      (rstn),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .pstrb_i   (pstrb_i),
      .cap0_i    (cap0),
      .cap1_i    (cap1),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .addr0_o   (addr0),
      .addr1_o   (addr1),
      .din0_o    (din0),
      .web0_o    (web0),
      .wmask0_o  (wmask0),
      .csb0_o    (csb0),
      .csb1_o    (csb1)
   );

   // bank 0 is the byte-wide one
   sram_tc_bank #(.DATA_T(byte_t), .DEPTH(`SRAM_TC_DEPTH0)) u_bank0 (
      .clk (clk), .rstn (rstn),
      .csb0_i (csb0[0]), .web0_i (web0), .wmask0_i (wmask0),
      .addr0_i (addr0), .din0_i (din0),
      .csb1_i (csb1[0]), .addr1_i (addr1),
      .data0_o (cap0[0]), .data1_o (cap1[0])
   );

   // word-wide banks, depth per index
   for (genvar g = 1; g < `SRAM_TC_NUM_BANKS; g++) begin : g_bank
      localparam int DEPTH = (g == 1) ? `SRAM_TC_DEPTH1 :
                             (g == 2) ? `SRAM_TC_DEPTH2 : `SRAM_TC_DEPTH3;
      sram_tc_bank #(.DATA_T(word_t), .DEPTH(DEPTH)) u_bank (
         .clk (clk), .rstn (rstn),
         .csb0_i (csb0[g]), .web0_i (web0), .wmask0_i (wmask0),
         .addr0_i (addr0), .din0_i (din0),
         .csb1_i (csb1[g]), .addr1_i (addr1),
         .data0_o (cap0[g]), .data1_o (cap1[g])
      );
   end

endmodule

`default_nettype wire

/* verification/sram_tc_sva.sv */
/*
 * sram test-chip protocol assertions
 * apb completion rules and chip-select reset state, bound to the top level
 */
`timescale 1ns/1ns
`default_nettype none

module sram_tc_sva (
   input logic                    clk,
   input logic                    rstn,
   input logic                    psel_i,
   input logic                    penable_i,
   input logic                    pready_i,
   input logic                    pslverr_i,
   input sram_tc_pkg::bank_mask_t csb0_i,
   input sram_tc_pkg::bank_mask_t csb1_i
);

   // completion only inside the access phase
   a_ready_in_access: assert property (@(posedge clk) disable iff (!rstn)
      pready_i |-> (psel_i && penable_i))
      else $error("pready_o high outside the access phase");

   // error flag rides on the completion cycle
   a_err_with_ready: assert property (@(posedge clk) disable iff (!rstn)
      pslverr_i |-> pready_i)
      else $error("pslverr_o high without pready_o");

   // single-cycle completion
   a_ready_pulse: assert property (@(posedge clk) disable iff (!rstn)
      pready_i |=> !pready_i)
      else $error("pready_o held high for two cycles");

   // sync reset, so the masks settle one edge into reset
   a_cs_reset: assert property (@(posedge clk)
      !rstn |=> ((csb0_i == '1) && (csb1_i == '1)))
      else $error("chip select active during reset");

endmodule

bind sram_tc_top sram_tc_sva u_sva (
   .clk       (clk),
   .rstn      (rstn),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_i  (pready_o),
   .pslverr_i (pslverr_o),
   .csb0_i    (csb0),
   .csb1_i    (csb1)
);

`default_nettype wire

/* verification/sram_tc_tb.sv */
/*
 * sram test-chip testbench
 * directed apb transfers over all banks, both ports, strobes and error paths
 */
`timescale 1ns/1ns
`default_nettype none

`include "sram_tc_config.svh"

module sram_tc_tb;
   import sram_tc_pkg::*;

   // roughly 70 transfers of at most 6 cycles plus reset, kept far above that
   localparam int TIMEOUT_CYCLES = 5000;

   logic                       clk;
   logic                       rstn;
   logic [`SRAM_TC_ADDR_W-1:0] paddr;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   word_t                      pwdata;
   strb_t                      pstrb;
   word_t                      prdata;
   logic                       pready;
   logic                       pslverr;

   integer seed;
   int     cycles = 0;
   int     errors;
   int     tests;
   int     depth [`SRAM_TC_NUM_BANKS];
   // outcome of the last transfer
   word_t  rd;
   logic   rerr;
   int     acc;

   sram_tc_top dut (
      .clk       (clk),
      .rstn      (rstn),
      .paddr_i   (paddr),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .pwdata_i  (pwdata),
      .pstrb_i   (pstrb),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout, run exceeded %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   // port bit, bank field, word address, byte offset
   function automatic logic [`SRAM_TC_ADDR_W-1:0] make_addr(input logic port,
                                                            input int bank, input int waddr);
      return {port, 4'(bank), 10'(waddr), 2'b00};
   endfunction

   // strobed lanes take the new byte
   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                         input strb_t strb);
      word_t res;
      res = old_w;
      for (int i = 0; i < 4; i++) begin
         if (strb[i]) begin
            res[8*i +: 8] = new_w[8*i +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // setup phase, then access phase until pready
   task automatic run_transfer(input logic wr, input logic [`SRAM_TC_ADDR_W-1:0] addr,
                               input word_t wdata, input strb_t strb);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      pstrb   = strb;
      @(posedge clk);
      #1;
      penable = 1'b1;
      acc     = 1;
      // sampled mid-cycle, clear of the edges
      @(negedge clk);
      while (pready !== 1'b1) begin
         @(negedge clk);
         acc++;
      end
      rd   = prdata;
      rerr = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [`SRAM_TC_ADDR_W-1:0] addr, input word_t data,
                            input strb_t strb);
      run_transfer(1'b1, addr, data, strb);
   endtask

   task automatic apb_read(input logic [`SRAM_TC_ADDR_W-1:0] addr);
      run_transfer(1'b0, addr, '0, '0);
   endtask

   // rejected transfer returns zero with the error flag
   task automatic check_rejected();
      check_err("pslverr_o", rerr, 1'b1);
      check_word("prdata_o", rd, '0);
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - errs_before);
      end
   endtask

   task automatic test_reset_rw();
      int    e0;
      int    pts [3];
      word_t d;
      e0 = errors;
      check_err("pready_o", pready, 1'b0);
      check_err("pslverr_o", pslverr, 1'b0);
      for (int b = 0; b < `SRAM_TC_NUM_BANKS; b++) begin
         pts = '{0, depth[b] / 2, depth[b] - 1};
         foreach (pts[k]) begin
            d = $random(seed);
            apb_write(make_addr(1'b0, b, pts[k]), d, 4'hf);
            apb_read(make_addr(1'b0, b, pts[k]));
            // bank 0 keeps the low byte only
            check_word("prdata_o", rd, (b == 0) ? {24'h0, d[7:0]} : d);
            check_err("pslverr_o", rerr, 1'b0);
         end
      end
      end_test("reset_readback", e0);
   endtask

   task automatic test_byte_strobe();
      int    e0;
      word_t d1;
      word_t d2;
      strb_t s [2];
      e0 = errors;
      s  = '{4'b0101, 4'b1010};
      for (int b = 1; b < 3; b++) begin
         d1 = $random(seed);
         d2 = $random(seed);
         apb_write(make_addr(1'b0, b, 37), d1, 4'hf);
         apb_write(make_addr(1'b0, b, 37), d2, s[b-1]);
         apb_read(make_addr(1'b0, b, 37));
         check_word("prdata_o", rd, merge_bytes(d1, d2, s[b-1]));
      end
      // bank 0 ignores the upper lanes
      apb_write(make_addr(1'b0, 0, 12), d1, 4'hf);
      apb_write(make_addr(1'b0, 0, 12), d2, 4'b1110);
      apb_read(make_addr(1'b0, 0, 12));
      check_word("prdata_o", rd, {24'h0, d1[7:0]});
      apb_write(make_addr(1'b0, 0, 12), d2, 4'b0001);
      apb_read(make_addr(1'b0, 0, 12));
      check_word("prdata_o", rd, {24'h0, d2[7:0]});
      end_test("byte_strobe", e0);
   endtask

   task automatic test_second_port();
      int    e0;
      word_t d;
      word_t r1;
      e0 = errors;
      for (int b = 0; b < `SRAM_TC_NUM_BANKS; b++) begin
         d = $random(seed);
         apb_write(make_addr(1'b0, b, 7 * b + 3), d, 4'hf);
         // read-only port first, the port 0 capture still holds an older word
         apb_read(make_addr(1'b1, b, 7 * b + 3));
         r1 = rd;
         check_word("prdata_o", r1, (b == 0) ? {24'h0, d[7:0]} : d);
         check_err("pslverr_o", rerr, 1'b0);
         apb_read(make_addr(1'b0, b, 7 * b + 3));
         check_word("prdata_o", rd, r1);
      end
      end_test("second_port", e0);
   endtask

   task automatic test_errors();
      int    e0;
      word_t d;
      word_t bad;
      e0  = errors;
      d   = $random(seed);
      bad = $random(seed);
      apb_write(make_addr(1'b0, 0, 0), ~bad, 4'hf);
      apb_write(make_addr(1'b0, 1, 0), d, 4'hf);
      apb_write(make_addr(1'b0, 2, 0), ~d, 4'hf);
      apb_write(make_addr(1'b0, 3, 7), d ^ 32'h5a5a_5a5a, 4'hf);
      // bank fields 4, 9 and 14 would alias onto banks 0 to 2
      for (int b = 4; b < 16; b += 5) begin
         apb_write(make_addr(1'b0, b, 0), bad, 4'hf);
         check_rejected();
         apb_read(make_addr(1'b0, b, 0));
         check_rejected();
      end
      // one past the depth, wraps onto word 0 if let through
      apb_write(make_addr(1'b0, 1, `SRAM_TC_DEPTH1), bad, 4'hf);
      check_rejected();
      apb_read(make_addr(1'b0, 1, `SRAM_TC_DEPTH1));
      check_rejected();
      apb_write(make_addr(1'b0, 2, `SRAM_TC_DEPTH2), bad, 4'hf);
      check_rejected();
      // read-only port
      apb_write(make_addr(1'b1, 3, 7), bad, 4'hf);
      check_rejected();
      apb_read(make_addr(1'b0, 0, 0));
      check_word("prdata_o", rd, {24'h0, ~bad[7:0]});
      apb_read(make_addr(1'b0, 1, 0));
      check_word("prdata_o", rd, d);
      apb_read(make_addr(1'b0, 2, 0));
      check_word("prdata_o", rd, ~d);
      apb_read(make_addr(1'b0, 3, 7));
      check_word("prdata_o", rd, d ^ 32'h5a5a_5a5a);
      end_test("errors", e0);
   endtask

   task automatic test_wait_states();
      int e0;
      e0 = errors;
      apb_write(make_addr(1'b0, 1, 9), $random(seed), 4'hf);
      check_cycles("pready_o write latency", acc, 2);
      apb_read(make_addr(1'b0, 1, 9));
      check_cycles("pready_o read latency", acc, 4);
      apb_read(make_addr(1'b1, 3, 9));
      check_cycles("pready_o read latency", acc, 4);
      apb_read(make_addr(1'b0, 5, 0));
      check_cycles("pready_o error latency", acc, 2);
      apb_write(make_addr(1'b0, 2, 600), '0, 4'hf);
      check_cycles("pready_o error latency", acc, 2);
      end_test("wait_states", e0);
   endtask

   initial begin
      clk     = 1'b0;
      rstn    = 1'b0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      pstrb   = '0;
      seed    = 41;
      errors  = 0;
      tests   = 0;
      depth   = '{`SRAM_TC_DEPTH0, `SRAM_TC_DEPTH1, `SRAM_TC_DEPTH2, `SRAM_TC_DEPTH3};
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;
      test_reset_rw();
      test_byte_strobe();
      test_second_port();
      test_errors();
      test_wait_states();
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
